// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = layer_tb
FILELIST  = files.f
BUILD_DIR = obj_dir
PASS_MSG  = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: common/lane_ctrl_if.sv
// Control bundle from the layer sequencer to the MAC lanes and the result read select
`timescale 1ns/10ps
interface lane_ctrl_if import layer_pkg::*; ();

  col_idx_t  col;        // Input index being multiplied
  row_idx_t  row;        // Neuron row being issued
  logic      mac_en;     // Product valid this cycle
  logic      row_start;  // Seed accumulator with bias
  logic      row_done;   // Accumulator final, store result
  row_idx_t  rd_row;     // Result row to read
  lane_idx_t rd_lane;    // Result lane to read

  modport sequencer (
    output col, row, mac_en, row_start, row_done, rd_row, rd_lane
  );

  modport lane (
    input col, row, mac_en, row_start, row_done, rd_row, rd_lane
  );

endinterface

// File: common/layer_coeffs.svh
// Weight and bias constants of the layer, indexed by lane, neuron row and input column
`ifndef LAYER_COEFFS_SVH
`define LAYER_COEFFS_SVH

  // WEIGHTS[lane][row][col]
  localparam data_t WEIGHTS [NUM_LANES][NUM_ROWS][NUM_INPUTS] = '{
    '{                                               // Lane 0
      '{ -49,    7,  -31,    7,   46,  -34,  -78,  -45},
      '{  26,  -49,   75,   65, -128,  100,    8,  -93},
      '{  84,    0,   60,    2,   94,  110,   85,   63},
      '{ -43, -114,   62,  -42,  115,  -58,   -7,   31},
      '{ -65, -102,  126,  -98, -119,   83,   93,   77},
      '{  15, -127,   76,    2,  -57,  -59,  -95,   10},
      '{ -85,   66,   95,  -76,   22,   60, -127,   -8},
      '{-128,  -71,   82,  -56,   -2,  115,   82,  -98}
    },
    '{                                               // Lane 1
      '{  96,   86,  -71,   -2,   43,  -44,   73,   83},
      '{  44,  124,   98, -126,  102,  -52,  -98,  -75},
      '{  68, -114,  -67,  -16,  -29, -122,  -61,  125},
      '{ -62,  -37,   33,  -88,   40,   63,  -34,   -4},
      '{  98, -102,  -67,  -59,  -96,    1,  -62,  -10},
      '{  32,   66,   50,  -56,    2, -112,   68,   65},
      '{  86,  -65,   61,  119,   64,  127,  -19,  -49},
      '{  54,    4,  -25,  -72,   21,  -85,  121,   64}
    }
  };

  // BIASES[lane][row]
  localparam data_t BIASES [NUM_LANES][NUM_ROWS] = '{
    '{110, 116,  21, 124, -76, -29,  56, -60},       // Lane 0
    '{ 89,   4, 117, -20,  57, 116,  80,  57}        // Lane 1
  };

`endif

// File: common/layer_pkg.sv
// Shared sizes, word and index types and coefficient tables for the 8-input 16-output layer
package layer_pkg;

  localparam int DATA_W      = 16;                   // One data word
  localparam int NUM_INPUTS  = 8;                    // Inputs per vector
  localparam int NUM_LANES   = 2;                    // Parallel MAC lanes
  localparam int NUM_ROWS    = 8;                    // Neurons per lane
  localparam int NUM_OUTPUTS = NUM_LANES * NUM_ROWS; // Results per vector

  // Signed data word used for inputs, coefficients and results
  typedef logic signed [DATA_W-1:0] data_t;

  typedef logic [$clog2(NUM_INPUTS)-1:0] col_idx_t;  // Input index
  typedef logic [$clog2(NUM_ROWS)-1:0]   row_idx_t;  // Neuron row within a lane
  typedef logic [$clog2(NUM_LANES)-1:0]  lane_idx_t; // Lane select

  // Weight and bias tables for both lanes
  `include "layer_coeffs.svh"

endpackage

// File: files.f
+incdir+common
common/layer_pkg.sv
common/lane_ctrl_if.sv
hw/layer/mac_lane.sv
hw/layer/layer_datapath.sv
hw/layer/layer_sequencer.sv
hw/layer_top.sv
verification/layer_tb.sv

// File: hw/layer/layer_datapath.sv
// Layer datapath with the input vector buffer, both MAC lanes and the output register
`timescale 1ns/10ps
module layer_datapath import layer_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  data_t     data_in,
  input  logic      x_wr,
  input  col_idx_t  x_addr,
  lane_ctrl_if.lane ctrl,
  output data_t     data_out
);

  data_t x_buf [NUM_INPUTS];   // Input vector, shared by both lanes
  data_t x_q;
  data_t lane_rd [NUM_LANES];

  always_ff @(posedge clk) begin
    if (x_wr) begin
      x_buf[x_addr] <= data_in;
    end
    x_q <= x_buf[ctrl.col];    // Lines up with the weight read
  end

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    mac_lane #(
      .LANE (l)
    ) i_mac_lane (
      .clk     (clk),
      .reset   (reset),
      .x       (x_q),
      .ctrl    (ctrl),
      .rd_data (lane_rd[l])
    );
  end

  // Output j comes from lane j mod 2
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else begin
      data_out <= lane_rd[ctrl.rd_lane];
    end
  end

endmodule

// File: hw/layer/layer_sequencer.sv
// Sequencer FSM that loads the input vector, steps both MAC lanes and streams the results out
`timescale 1ns/10ps
module layer_sequencer import layer_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic           s_valid,
  output logic           s_ready,
  input  logic           m_ready,
  output logic           m_valid,
  output logic           x_wr,
  output col_idx_t       x_addr,
  lane_ctrl_if.sequencer ctrl
);

  typedef enum logic [1:0] {
    LOAD,
    COMPUTE,
    OUTPUT
  } state_t;

  localparam int OUT_W = $clog2(NUM_OUTPUTS);
  localparam col_idx_t LAST_COL = col_idx_t'(NUM_INPUTS - 1);
  localparam row_idx_t LAST_ROW = row_idx_t'(NUM_ROWS - 1);
  localparam logic [OUT_W-1:0] LAST_OUT = OUT_W'(NUM_OUTPUTS - 1);

  state_t           state;
  col_idx_t         in_cnt;      // Next input slot to fill
  col_idx_t         col_cnt;     // Issue column
  row_idx_t         row_cnt;     // Issue row
  logic [OUT_W-1:0] out_cnt;     // Index of the word offered on data_out
  logic [OUT_W-1:0] rd_idx;
  logic             issue_busy;  // Still issuing columns
  logic             issue;
  logic             in_xfer;
  logic             out_xfer;
  logic [1:0]       mac_d;       // Read and multiply stages
  logic [1:0]       start_d;
  logic [2:0]       done_d;      // One more stage for the final add

  assign s_ready  = (state == LOAD);
  assign in_xfer  = s_valid && s_ready;
  assign out_xfer = m_valid && m_ready;

  assign x_wr   = in_xfer;
  assign x_addr = in_cnt;

  assign issue = (state == COMPUTE) && issue_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= LOAD;
      in_cnt     <= '0;
      col_cnt    <= '0;
      row_cnt    <= '0;
      out_cnt    <= '0;
      issue_busy <= 1'b0;
      m_valid    <= 1'b0;
    end else begin
      case (state)
        LOAD: begin
          if (in_xfer) begin
            in_cnt <= in_cnt + 1'b1;  // Wraps back to zero after the last word
            if (in_cnt == LAST_COL) begin
              state      <= COMPUTE;
              issue_busy <= 1'b1;
            end
          end
        end
        COMPUTE: begin
          if (issue) begin
            col_cnt <= col_cnt + 1'b1;
            if (col_cnt == LAST_COL) begin
              row_cnt <= row_cnt + 1'b1;
              if (row_cnt == LAST_ROW) begin
                issue_busy <= 1'b0;
              end
            end
          end
          // Only the last row can finish once issuing has stopped
          if (!issue_busy && done_d[2]) begin
            state <= OUTPUT;
          end
        end
        OUTPUT: begin
          if (!m_valid) begin
            m_valid <= 1'b1;          // Word 0 is registered by now
          end else if (m_ready) begin
            out_cnt <= out_cnt + 1'b1;
            if (out_cnt == LAST_OUT) begin
              m_valid <= 1'b0;
              state   <= LOAD;
            end
          end
        end
        default: state <= LOAD;
      endcase
    end
  end

  // Align control with the two-cycle read and multiply pipeline
  always_ff @(posedge clk) begin
    if (reset) begin
      mac_d   <= '0;
      start_d <= '0;
      done_d  <= '0;
    end else begin
      mac_d   <= {mac_d[0], issue};
      start_d <= {start_d[0], issue && (col_cnt == '0)};
      done_d  <= {done_d[1:0], issue && (col_cnt == LAST_COL)};
    end
  end

  assign ctrl.col       = col_cnt;
  assign ctrl.row       = row_cnt;
  assign ctrl.mac_en    = mac_d[1];
  assign ctrl.row_start = start_d[1];
  assign ctrl.row_done  = done_d[2];

  // Look ahead one word on a transfer so the next result is ready a cycle later
  assign rd_idx       = out_cnt + OUT_W'(out_xfer);
  assign ctrl.rd_row  = rd_idx[OUT_W-1:1];
  assign ctrl.rd_lane = rd_idx[0];

endmodule

// File: hw/layer/mac_lane.sv
// One MAC lane computing eight neurons with bias, wrapping accumulation and ReLU
`timescale 1ns/10ps
module mac_lane import layer_pkg::*; #(
  parameter int LANE = 0
) (
  input  logic      clk,
  input  logic      reset,
  input  data_t     x,
  lane_ctrl_if.lane ctrl,
  output data_t     rd_data
);

  data_t                      w_q;
  data_t                      bias_q;
  data_t                      bias_p;
  data_t                      prod;
  data_t                      acc;
  data_t                      acc_base;
  row_idx_t                   row_q;
  row_idx_t                   row_p;
  row_idx_t                   acc_row;     // Row held in the accumulator
  logic signed [2*DATA_W-1:0] full_prod;
  data_t                      res_mem [NUM_ROWS];

  // Coefficient read stage
  always_ff @(posedge clk) begin
    w_q    <= WEIGHTS[LANE][ctrl.row][ctrl.col];
    bias_q <= BIASES[LANE][ctrl.row];
    row_q  <= ctrl.row;
  end

  assign full_prod = x * w_q;

  // Multiply stage, only the low word is kept
  always_ff @(posedge clk) begin
    prod   <= full_prod[DATA_W-1:0];
    bias_p <= bias_q;
    row_p  <= row_q;
  end

  // First product of a row adds onto the bias instead of the old sum
  assign acc_base = ctrl.row_start ? bias_p : acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc     <= '0;
      acc_row <= '0;
    end else begin
      if (ctrl.mac_en) begin
        acc <= acc_base + prod;   // Wraps modulo 2^16
      end
      if (ctrl.row_start) begin
        acc_row <= row_p;
      end
    end
  end

  // row_done sees the finished sum of the previous row even while the next one starts
  always_ff @(posedge clk) begin
    if (ctrl.row_done) begin
      res_mem[acc_row] <= acc[DATA_W-1] ? '0 : acc;  // ReLU
    end
  end

  assign rd_data = res_mem[ctrl.rd_row];

endmodule

// File: hw/layer_top.sv
// Top level of the fully connected layer with valid/ready input and output streams
`timescale 1ns/10ps
module layer_top import layer_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  s_valid,
  output logic  s_ready,
  input  data_t data_in,
  output logic  m_valid,
  input  logic  m_ready,
  output data_t data_out
);

  logic     x_wr;
  col_idx_t x_addr;

  lane_ctrl_if i_lane_ctrl ();

  layer_sequencer i_sequencer (
    .clk     (clk),
    .reset   (reset),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .x_wr    (x_wr),
    .x_addr  (x_addr),
    .ctrl    (i_lane_ctrl.sequencer)
  );

  layer_datapath i_datapath (
    .clk      (clk),
    .reset    (reset),
    .data_in  (data_in),
    .x_wr     (x_wr),
    .x_addr   (x_addr),
    .ctrl     (i_lane_ctrl.lane),
    .data_out (data_out)
  );

endmodule

// File: verification/layer_tb.sv
// Testbench for the layer that streams random vectors in and checks every result against a model
`timescale 1ns/10ps
module layer_tb import layer_pkg::*; ();

  localparam int NUM_VECTORS    = 20;
  localparam int TOTAL_OUT      = NUM_VECTORS * NUM_OUTPUTS;
  localparam int TIMEOUT_CYCLES = NUM_VECTORS * 400;  // 400-cycle bound per vector

  typedef data_t vec_t [NUM_INPUTS];

  logic   clk;
  logic   reset;
  logic   s_valid;
  logic   s_ready;
  data_t  data_in;
  logic   m_valid;
  logic   m_ready;
  data_t  data_out;

  integer seed;
  vec_t   cur_vec;                // Vector being loaded
  data_t  expected_q [$];         // Results still to come in output order
  int     in_total  = 0;          // Input transfers seen
  int     out_total = 0;          // Output transfers seen
  int     cycle_cnt = 0;
  logic   held      = 1'b0;       // Last cycle was back-pressured
  data_t  held_word;
  int     vec_idx;
  int     word_idx;

  layer_top i_layer_top (
    .clk      (clk),
    .reset    (reset),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .data_in  (data_in),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .data_out (data_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reference model with bias, wrapped 16-bit products and sum, then ReLU
  function automatic data_t expected_output(input vec_t x, input int j);
    lane_idx_t                  lane;
    row_idx_t                   row;
    data_t                      acc;
    logic signed [2*DATA_W-1:0] full;
    lane = lane_idx_t'(j % NUM_LANES);
    row  = row_idx_t'(j / NUM_LANES);
    acc  = BIASES[lane][row];
    for (int c = 0; c < NUM_INPUTS; c++) begin
      full = 32'(x[col_idx_t'(c)]) * 32'(WEIGHTS[lane][row][col_idx_t'(c)]);
      acc  = acc + data_t'(full[DATA_W-1:0]);
    end
    if (acc[DATA_W-1]) begin
      acc = '0;
    end
    return acc;
  endfunction

  task automatic check_value(input int actual, input int expected, input string what);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s, got %0d, expected %0d", $time, what, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // Fill the next vector and queue its 16 expected results
  task automatic start_vector(input int v);
    int r;
    for (int i = 0; i < NUM_INPUTS; i++) begin
      r = $random(seed);
      if (v == 0) begin
        cur_vec[col_idx_t'(i)] = '0;                                // Outputs equal the biases
      end else begin
        case (r & 3)
          0:       cur_vec[col_idx_t'(i)] = data_t'(32767 - ((r >>> 2) & 7));   // Near +max
          1:       cur_vec[col_idx_t'(i)] = data_t'(-32768 + ((r >>> 2) & 7));  // Near -max
          default: cur_vec[col_idx_t'(i)] = data_t'(r >>> 8);
        endcase
      end
    end
    for (int j = 0; j < NUM_OUTPUTS; j++) begin
      expected_q.push_back(expected_output(cur_vec, j));
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run hung after %0d cycles with %0d of %0d results received",
               cycle_cnt, out_total, TOTAL_OUT);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  end

  // Stimulus driven 2 ns after each rising edge
  initial begin
    seed     = 32'h8afd476f;
    reset    = 1'b1;
    s_valid  = 1'b0;
    data_in  = '0;
    m_ready  = 1'b0;
    vec_idx  = 0;
    word_idx = 0;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    check_value(int'(m_valid), 0, "m_valid after reset");
    check_value(int'(s_ready), 1, "s_ready after reset");
    start_vector(0);
    while (out_total < TOTAL_OUT) begin
      // Every third vector drains without back-pressure
      m_ready = ((out_total / NUM_OUTPUTS) % 3 == 0) ? 1'b1 : (($random(seed) & 7) > 2);
      if (vec_idx < NUM_VECTORS) begin
        s_valid = (vec_idx % 2 == 0) ? 1'b1 : (($random(seed) & 3) != 0);  // Gaps on odd ones
        data_in = cur_vec[col_idx_t'(word_idx)];
        if (s_valid && s_ready) begin
          word_idx++;
          if (word_idx == NUM_INPUTS) begin
            word_idx = 0;
            vec_idx++;
            if (vec_idx < NUM_VECTORS) begin
              start_vector(vec_idx);
            end
          end
        end
      end else begin
        s_valid = 1'b0;
        data_in = '0;
      end
      @(posedge clk);
      #2;
    end
    m_ready = 1'b0;
    s_valid = 1'b0;
    check_value(int'(m_valid), 0, "m_valid after the last result");
    check_value(int'(s_ready), 1, "s_ready after the last result");
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Monitor and checker sampled on the falling edge where all signals are settled
  always @(negedge clk) begin
    if (!reset) begin
      if (held) begin
        check_value(int'(m_valid), 1, "m_valid dropped under back-pressure");
        check_value(int'(data_out), int'(held_word), "data_out changed under back-pressure");
      end
      held      = m_valid && !m_ready;
      held_word = data_out;
      if (s_valid && s_ready) begin
        check_value(in_total / NUM_INPUTS, out_total / NUM_OUTPUTS,
                    "input taken before the previous results were sent");
        in_total++;
      end
      if (m_valid && m_ready) begin
        check_value(in_total / NUM_INPUTS, out_total / NUM_OUTPUTS + 1,
                    "output offered before its vector was loaded");
        if (expected_q.size() == 0) begin
          $display("An output word was taken with no expected result left");
          $display("TEST RESULT: FAIL");
          $fatal(1);
        end else begin
          check_value(int'(data_out), int'(expected_q.pop_front()),
                      $sformatf("vector %0d output %0d", out_total / NUM_OUTPUTS,
                                out_total % NUM_OUTPUTS));
          out_total++;
        end
      end
    end
  end

endmodule
